// File: testbench/rename_stim.txt
# dispatch arch_reg cdb_valid cdb_index flush expected_grant
# arch_reg 99 means a random register, cdb_index counts from the oldest in-flight instruction
1 1 0 0 0 1
1 2 0 0 0 1
1 1 0 0 0 1
1 99 0 0 0 1
1 7 0 0 0 1
1 2 0 0 0 1
1 99 0 0 0 1
1 12 0 0 0 1
1 31 0 0 0 1
1 0 0 0 0 1
1 99 0 0 0 1
1 7 0 0 0 1
1 20 0 0 0 1
1 99 0 0 0 1
1 1 0 0 0 1
1 25 0 0 0 1
1 3 1 2 0 0
1 3 1 1 0 0
1 3 1 0 0 0
1 3 1 4 0 0
1 3 1 2 0 1
1 4 1 3 0 1
1 99 1 3 0 1
1 5 1 3 0 1
1 6 1 3 0 1
1 99 1 3 0 1
1 8 1 3 0 1
1 9 1 3 0 1
1 99 1 3 0 1
1 10 1 3 0 1
1 3 1 3 0 1
1 11 1 3 0 1
1 99 1 3 0 1
1 14 1 3 0 1
1 2 1 3 0 1
1 99 1 3 0 1
1 17 1 3 0 1
1 1 1 3 0 1
0 0 0 0 1 0
1 1 0 0 0 1
1 99 0 0 0 1
0 0 1 0 0 0
0 0 0 0 0 0
0 0 1 0 0 0
0 0 0 0 0 0

// File: all.f
common/rename_pkg.sv
rob/reorder_buffer.sv
source/free_list.sv
source/map_table.sv
source/arch_map.sv
source/rename_core.sv
testbench/rename_core_tb.sv

// File: Makefile
TOP = rename_core_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: testbench/rename_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core_tb import rename_pkg::*; ();

	localparam int rob_depth = ROB_DEPTH_DEFAULT;

	logic clock;
	logic arst_n;
	logic dispatch;
	arch_reg_t dispatch_arch_reg;
	logic cdb_valid;
	phys_reg_t cdb_tag;
	logic flush;
	logic dispatch_grant;
	phys_reg_t dispatch_t_new;
	phys_reg_t dispatch_t_old;
	logic retire_valid;
	arch_reg_t retire_arch_reg;
	phys_reg_t retire_t_new;
	phys_reg_t retire_t_old;
	logic [$clog2(rob_depth):0] rob_free_entries;

	// Stimulus columns with one entry per data line
	int s_disp[$], s_reg[$], s_cdb[$], s_idx[$], s_flush[$], s_grant[$];
	int n_lines = 0;
	integer seed = 31829;

	// Reference model
	int pool[$];              // Free tags in hand-out order from the committed point
	int spec_map[ARCH_REGS];  // Speculative mapping
	int commit_map[ARCH_REGS]; // Retired mapping
	int inf_reg[$], inf_new[$], inf_old[$], inf_rdy[$]; // In-flight instructions oldest first

	always #4 clock = ~clock;

	rename_core #(
		.rob_depth(rob_depth)
	) uut (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch(dispatch),
		.dispatch_arch_reg(dispatch_arch_reg),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.flush(flush),
		.dispatch_grant(dispatch_grant),
		.dispatch_t_new(dispatch_t_new),
		.dispatch_t_old(dispatch_t_old),
		.retire_valid(retire_valid),
		.retire_arch_reg(retire_arch_reg),
		.retire_t_new(retire_t_new),
		.retire_t_old(retire_t_old),
		.rob_free_entries(rob_free_entries)
	);

	task automatic check_value(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("test failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int d, r, c, x, f, g;
		string line;
		fd = $fopen("testbench/rename_stim.txt", "r");
		if (fd == 0) begin
			$display("test failed");
			$fatal(1, "Could not open the stimulus file testbench/rename_stim.txt");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 1 && line.getc(0) != "#") begin // Skip column notes
				if ($sscanf(line, "%d %d %d %d %d %d", d, r, c, x, f, g) == 6) begin
					s_disp.push_back(d);
					s_reg.push_back(r);
					s_cdb.push_back(c);
					s_idx.push_back(x);
					s_flush.push_back(f);
					s_grant.push_back(g);
				end
			end
		end
		$fclose(fd);
		n_lines = s_disp.size();
	endtask

	task automatic apply_line(input int k);
		int n;
		int reg_v;
		int exp_grant;
		int exp_retire;
		int exp_new;
		int exp_old;
		@(negedge clock);
		n = inf_new.size();
		reg_v = (s_reg[k] == 99) ? ($random(seed) & 31) : s_reg[k]; // 99 picks a register
		if (s_cdb[k] != 0 && s_idx[k] >= n) begin
			$display("test failed");
			$fatal(1, "Stimulus line %0d broadcasts an instruction that is not in flight", k);
		end
		dispatch = (s_disp[k] != 0);
		dispatch_arch_reg = arch_reg_t'(reg_v);
		cdb_valid = (s_cdb[k] != 0);
		cdb_tag = cdb_valid ? phys_reg_t'(inf_new[s_idx[k]]) : '0;
		flush = (s_flush[k] != 0);
		// Room in the ROB and a tag left in the pool
		exp_grant = (s_disp[k] != 0 && n < rob_depth && n < pool.size()) ? 1 : 0;
		exp_retire = (n > 0 && s_flush[k] == 0 && inf_rdy[0] != 0) ? 1 : 0;
		exp_new = (n < pool.size()) ? pool[n] : 0;
		exp_old = spec_map[reg_v];
		#3; // Just before the rising edge
		check_value(int'(dispatch_grant), s_grant[k], "dispatch_grant against stimulus file");
		check_value(int'(dispatch_grant), exp_grant, "dispatch_grant");
		check_value(int'(rob_free_entries), rob_depth - n, "rob_free_entries");
		check_value(int'(retire_valid), exp_retire, "retire_valid");
		if (exp_retire != 0) begin
			check_value(int'(retire_arch_reg), inf_reg[0], "retire_arch_reg");
			check_value(int'(retire_t_new), inf_new[0], "retire_t_new");
			check_value(int'(retire_t_old), inf_old[0], "retire_t_old");
		end
		if (exp_grant != 0) begin
			check_value(int'(dispatch_t_new), exp_new, "dispatch_t_new");
			check_value(int'(dispatch_t_old), exp_old, "dispatch_t_old");
		end
		@(posedge clock);
		if (s_flush[k] != 0) begin // Squash all and fall back to the committed map
			inf_reg.delete();
			inf_new.delete();
			inf_old.delete();
			inf_rdy.delete();
			spec_map = commit_map;
		end else begin
			if (s_cdb[k] != 0)
				inf_rdy[s_idx[k]] = 1;
			if (exp_retire != 0) begin
				commit_map[inf_reg[0]] = inf_new[0];
				void'(pool.pop_front());    // Retired tag is now committed
				pool.push_back(inf_old[0]); // Old tag handed out again last
				void'(inf_reg.pop_front());
				void'(inf_new.pop_front());
				void'(inf_old.pop_front());
				void'(inf_rdy.pop_front());
			end
			if (exp_grant != 0) begin
				inf_reg.push_back(reg_v);
				inf_new.push_back(exp_new);
				inf_old.push_back(exp_old);
				inf_rdy.push_back(0);
				spec_map[reg_v] = exp_new;
			end
		end
	endtask

	// Watchdog sized from the stimulus length
	initial begin
		wait (n_lines > 0);
		#((n_lines + 40) * 8);
		$display("test failed");
		$fatal(1, "Simulation timed out after %0d stimulus lines", n_lines);
	end

	initial begin
		clock = 1'b0;
		arst_n = 1'b0;
		dispatch = 1'b0;
		dispatch_arch_reg = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		flush = 1'b0;
		for (int i = 0; i < ARCH_REGS; i++) begin
			spec_map[i] = i; // Identity after reset
			commit_map[i] = i;
		end
		for (int t = ARCH_REGS; t < PHYS_REGS; t++)
			pool.push_back(t);
		load_stimulus();
		if (n_lines == 0) begin
			$display("test failed");
			$fatal(1, "The stimulus file holds no data lines");
		end
		repeat (16) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		for (int k = 0; k < n_lines; k++)
			apply_line(k);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/rename_core.sv
`timescale 1ns/1ps
`default_nettype none

module rename_core import rename_pkg::*; #(
	parameter int rob_depth = ROB_DEPTH_DEFAULT // Power of two, 4 to 32
) (
	input  wire logic                  clock,
	input  wire logic                  arst_n,
	input  wire logic                  dispatch,
	input  wire arch_reg_t             dispatch_arch_reg,
	input  wire logic                  cdb_valid,
	input  wire phys_reg_t             cdb_tag,
	input  wire logic                  flush,
	output logic                       dispatch_grant,
	output phys_reg_t                  dispatch_t_new,
	output phys_reg_t                  dispatch_t_old,
	output logic                       retire_valid,
	output arch_reg_t                  retire_arch_reg,
	output phys_reg_t                  retire_t_new,
	output phys_reg_t                  retire_t_old,
	output logic [$clog2(rob_depth):0] rob_free_entries
);

	logic rob_full;                       // ROB back-pressure into the gate
	phys_reg_t [ARCH_REGS-1:0] arch_tags; // Restore source for the map table

	reorder_buffer #(
		.rob_depth(rob_depth)
	) u_reorder_buffer (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch_grant(dispatch_grant),
		.dispatch_arch_reg(dispatch_arch_reg),
		.dispatch_t_new(dispatch_t_new),
		.dispatch_t_old(dispatch_t_old),
		.cdb_valid(cdb_valid),
		.cdb_tag(cdb_tag),
		.flush(flush),
		.rob_full(rob_full),
		.rob_free_entries(rob_free_entries),
		.retire_valid(retire_valid),
		.retire_arch_reg(retire_arch_reg),
		.retire_t_new(retire_t_new),
		.retire_t_old(retire_t_old)
	);

	// Also the dispatch gate
	free_list u_free_list (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch(dispatch),
		.rob_full(rob_full),
		.retire_valid(retire_valid),
		.retire_t_old(retire_t_old),
		.flush(flush),
		.dispatch_grant(dispatch_grant),
		.dispatch_t_new(dispatch_t_new)
	);

	map_table u_map_table (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch_grant(dispatch_grant),
		.dispatch_arch_reg(dispatch_arch_reg),
		.dispatch_t_new(dispatch_t_new),
		.flush(flush),
		.arch_tags(arch_tags),
		.dispatch_t_old(dispatch_t_old)
	);

	arch_map u_arch_map (
		.clock(clock),
		.arst_n(arst_n),
		.retire_valid(retire_valid),
		.retire_arch_reg(retire_arch_reg),
		.retire_t_new(retire_t_new),
		.arch_tags(arch_tags)
	);

endmodule

`default_nettype wire

// File: source/arch_map.sv
`timescale 1ns/1ps
`default_nettype none

module arch_map import rename_pkg::*; (
	input  wire logic                 clock,
	input  wire logic                 arst_n,
	input  wire logic                 retire_valid,
	input  wire arch_reg_t            retire_arch_reg,
	input  wire phys_reg_t            retire_t_new,
	output phys_reg_t [ARCH_REGS-1:0] arch_tags // Feeds the map table restore
);

	// Committed mappings, only touched at retire
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				arch_tags[i] <= phys_reg_t'(i);
			end
		end else if (retire_valid) begin
			arch_tags[retire_arch_reg] <= retire_t_new;
		end
	end

	// Retiring tag replaces a different committed one
	retire_new_mapping: assert property (@(posedge clock) disable iff (!arst_n)
		retire_valid |-> (arch_tags[retire_arch_reg] != retire_t_new));

endmodule

`default_nettype wire

// File: source/map_table.sv
`timescale 1ns/1ps
`default_nettype none

module map_table import rename_pkg::*; (
	input  wire logic                       clock,
	input  wire logic                       arst_n,
	input  wire logic                       dispatch_grant,
	input  wire arch_reg_t                  dispatch_arch_reg,
	input  wire phys_reg_t                  dispatch_t_new,
	input  wire logic                       flush,
	input  wire phys_reg_t [ARCH_REGS-1:0]  arch_tags, // Committed state for restore
	output phys_reg_t                       dispatch_t_old
);

	// Speculative mapping, one tag per architectural register
	phys_reg_t [ARCH_REGS-1:0] map_q;

	// Previous mapping goes to the ROB so it can be freed at retire
	assign dispatch_t_old = map_q[dispatch_arch_reg];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ARCH_REGS; i++) begin
				map_q[i] <= phys_reg_t'(i); // Identity mapping
			end
		end else if (flush) begin
			map_q <= arch_tags; // Whole table in one cycle
		end else if (dispatch_grant) begin
			map_q[dispatch_arch_reg] <= dispatch_t_new;
		end
	end

	// A tag coming off the free list is never already mapped
	new_tag_unmapped: assert property (@(posedge clock) disable iff (!arst_n)
		dispatch_grant |-> (dispatch_t_new != dispatch_t_old));

endmodule

`default_nettype wire

// File: source/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list import rename_pkg::*; (
	input  wire logic      clock,
	input  wire logic      arst_n,
	input  wire logic      dispatch,
	input  wire logic      rob_full,
	input  wire logic      retire_valid,
	input  wire phys_reg_t retire_t_old, // Released at retire
	input  wire logic      flush,
	output logic           dispatch_grant,
	output phys_reg_t      dispatch_t_new
);

	phys_reg_t store [FREE_REGS];

	free_ptr_t wr_ptr;     // Where released tags go
	free_ptr_t spec_ptr;   // Next tag handed to dispatch
	free_ptr_t commit_ptr; // Oldest tag not yet retired

	logic empty;

	// Same slot and same wrap means nothing left to hand out
	assign empty = (spec_ptr == wr_ptr);

	// Dispatch gate
	assign dispatch_grant = dispatch & ~rob_full & ~empty;
	assign dispatch_t_new = store[free_idx_t'(spec_ptr)];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			spec_ptr <= '0;
			commit_ptr <= '0;
			wr_ptr <= free_ptr_t'(FREE_REGS); // Full, wrap bit differs
			for (int i = 0; i < FREE_REGS; i++) begin
				store[i] <= phys_reg_t'(ARCH_REGS + i); // Tags above the arch set
			end
		end else begin
			if (flush) begin
				spec_ptr <= commit_ptr; // Squashed tags become free again
			end else if (dispatch_grant) begin
				spec_ptr <= spec_ptr + free_ptr_t'(1);
			end
			if (retire_valid) begin
				// Old tag lands in the slot the retiring new tag came from
				store[free_idx_t'(wr_ptr)] <= retire_t_old;
				wr_ptr <= wr_ptr + free_ptr_t'(1);
				commit_ptr <= commit_ptr + free_ptr_t'(1);
			end
		end
	end

	// Retire needs an allocated, uncommitted tag behind it
	retire_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
		retire_valid |-> (spec_ptr != commit_ptr));

endmodule

`default_nettype wire

// File: rob/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import rename_pkg::*; #(
	parameter int rob_depth = ROB_DEPTH_DEFAULT
) (
	input  wire logic                        clock,
	input  wire logic                        arst_n,
	input  wire logic                        dispatch_grant, // From the free list
	input  wire arch_reg_t                   dispatch_arch_reg,
	input  wire phys_reg_t                   dispatch_t_new,
	input  wire phys_reg_t                   dispatch_t_old,
	input  wire logic                        cdb_valid,
	input  wire phys_reg_t                   cdb_tag,
	input  wire logic                        flush,
	output logic                             rob_full,
	output logic [$clog2(rob_depth):0]       rob_free_entries,
	output logic                             retire_valid,
	output arch_reg_t                        retire_arch_reg,
	output phys_reg_t                        retire_t_new,
	output phys_reg_t                        retire_t_old
);

	localparam int idx_w = $clog2(rob_depth);
	localparam int cnt_w = idx_w + 1; // Needs to hold rob_depth itself

	typedef logic [idx_w-1:0] rob_idx_t;
	typedef logic [cnt_w-1:0] rob_cnt_t;

	// Per-entry control flags
	logic [rob_depth-1:0] busy;
	logic [rob_depth-1:0] ready;
	logic [rob_depth-1:0] cdb_hit; // Tag-match row

	// Per-entry payload
	arch_reg_t entry_arch_reg [rob_depth];
	phys_reg_t entry_t_new [rob_depth];
	phys_reg_t entry_t_old [rob_depth];

	rob_idx_t head; // Oldest instruction
	rob_idx_t tail; // Next free slot
	rob_cnt_t count;

	// One comparator per entry against the broadcast tag
	always_comb begin
		for (int i = 0; i < rob_depth; i++) begin
			cdb_hit[i] = cdb_valid & busy[i] & (entry_t_new[i] == cdb_tag);
		end
	end

	assign rob_full = (count == rob_cnt_t'(rob_depth));
	assign rob_free_entries = rob_cnt_t'(rob_depth) - count;

	// Head retires once its result has been seen on the CDB
	assign retire_valid = busy[head] & ready[head] & ~flush;
	assign retire_arch_reg = entry_arch_reg[head];
	assign retire_t_new = entry_t_new[head];
	assign retire_t_old = entry_t_old[head];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= '0;
			ready <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (flush) begin // Squash everything in flight
			busy <= '0;
			ready <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			ready <= ready | cdb_hit; // Completion marks
			if (retire_valid) begin
				busy[head] <= 1'b0;
				head <= head + rob_idx_t'(1);
			end
			if (dispatch_grant) begin // Tail never equals a retiring head here
				busy[tail] <= 1'b1;
				ready[tail] <= 1'b0;
				tail <= tail + rob_idx_t'(1);
			end
			count <= count + rob_cnt_t'(dispatch_grant) - rob_cnt_t'(retire_valid);
		end
	end

	// Payload captured at the tail on grant
	always_ff @(posedge clock) begin
		if (dispatch_grant) begin
			entry_arch_reg[tail] <= dispatch_arch_reg;
			entry_t_new[tail] <= dispatch_t_new;
			entry_t_old[tail] <= dispatch_t_old;
		end
	end

	// Free list must honour the full flag
	grant_not_full: assert property (@(posedge clock) disable iff (!arst_n)
		rob_full |-> !dispatch_grant);

	// A retiring head implies the counter sees at least one entry
	retire_not_idle: assert property (@(posedge clock) disable iff (!arst_n)
		retire_valid |-> (count != '0));

	count_bounded: assert property (@(posedge clock) disable iff (!arst_n)
		count <= rob_cnt_t'(rob_depth));

	// Tags in flight are unique, so a broadcast hits at most one entry
	cdb_single_hit: assert property (@(posedge clock) disable iff (!arst_n)
		$onehot0(cdb_hit));

endmodule

`default_nettype wire

// File: common/rename_pkg.sv
`default_nettype none

package rename_pkg;

	// Register file sizes
	localparam int ARCH_REGS = 32; // Architectural registers seen by software
	localparam int PHYS_REGS = 64; // Physical registers behind the renamer

	// Tags not covered by a committed mapping sit in the free list
	localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;

	// Default reorder buffer depth, overridden from the top level
	localparam int ROB_DEPTH_DEFAULT = 16;

	// Architectural register number
	typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t;

	// Physical register tag
	typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t;

	// Slot index into the free list store
	typedef logic [$clog2(FREE_REGS)-1:0] free_idx_t;

	// Free list pointer, slot index plus a wrap bit
	typedef logic [$clog2(FREE_REGS):0] free_ptr_t;

endpackage

`default_nettype wire
